//--- logic/nonce_tracker.sv
/*
 * Nonce tracker, input side of the core
 * Keeps the prefixed nonce counter and parks one tagged block for the mixer
 */
`timescale 1ns/1ps
`default_nettype none

module nonce_tracker #(
	parameter int unsigned CORE_ID = 0
) (
	input logic hash_clk,
	input logic reset,
	input logic block_valid,
	input scrypt_pkg::block_t block_in,
	input scrypt_pkg::word_t nonce_seed,
	input logic load_nonce,
	input logic take,	// Mixer has picked up the job
	output logic pending_valid,
	output scrypt_pkg::work_t pending_work,
	output scrypt_pkg::nonce_t nonce_out
);
	import scrypt_pkg::*;

	localparam int COUNT_BITS = $bits(nonce_t) - CORE_ID_BITS;
	localparam logic [CORE_ID_BITS-1:0] ID_PREFIX = CORE_ID[CORE_ID_BITS-1:0];

	logic [COUNT_BITS-1:0] count;	// Low part of the nonce
	word_t last_seed;	// Seed seen at the last reload
	logic accept;

	assign accept = block_valid && !pending_valid;	// Slot full means the block is lost
	assign nonce_out = {ID_PREFIX, count};

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			count <= '0;
			last_seed <= '0;
			pending_valid <= 1'b0;
		end else begin
			if (load_nonce || (nonce_seed != last_seed)) begin
				count <= nonce_seed[COUNT_BITS-1:0];	// Prefix bits of the seed are ignored
				last_seed <= nonce_seed;
			end
			if (accept) begin
				count <= count + 1'b1;	// Increment wins over a reload in the same cycle
				pending_valid <= 1'b1;
			end else if (take) begin
				pending_valid <= 1'b0;
			end
		end
	end

	// Job payload, tagged with the nonce current at acceptance
	always_ff @(posedge hash_clk) begin
		if (accept) begin
			pending_work.block <= block_in;
			pending_work.nonce <= nonce_out;
		end
	end

endmodule

`default_nettype wire

//--- logic/result_check.sv
/*
 * Result check, output side of the core
 * Registers the mixed block and flags a golden nonce on a target hit
 */
`timescale 1ns/1ps
`default_nettype none

module result_check (
	input logic hash_clk,
	input logic reset,
	input logic mix_done,
	input scrypt_pkg::result_t mix_result,
	input scrypt_pkg::word_t target,
	output logic result_valid,
	output scrypt_pkg::result_t result,
	output logic golden_match,
	output scrypt_pkg::nonce_t golden_nonce
);
	import scrypt_pkg::*;

	word_t top_word;
	word_t top_reversed;

	assign top_word = mix_result.block[1023:992];
	// Byte order swapped before the compare
	assign top_reversed = {top_word[7:0], top_word[15:8], top_word[23:16], top_word[31:24]};

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			golden_match <= 1'b0;
			golden_nonce <= '0;
		end else begin
			result_valid <= mix_done;
			golden_match <= 1'b0;	// One cycle strobe
			if (mix_done && (top_reversed < target)) begin
				golden_match <= 1'b1;
				golden_nonce <= mix_result.nonce;	// Held until the next hit
			end
		end
	end

	always_ff @(posedge hash_clk) begin
		if (mix_done)
			result <= mix_result;
	end

endmodule

`default_nettype wire

//--- logic/romix_engine.sv
/*
 * ROMix mixer
 * Fills the scratchpad while running BlockMix, then mixes it back in by
 * data-dependent address, with one Salsa20/8 core doing both passes
 */
`timescale 1ns/1ps
`default_nettype none

module romix_engine #(
	parameter int SCRATCH_ADDR_BITS = 10
) (
	input logic hash_clk,
	input logic reset,
	input logic pending_valid,
	input scrypt_pkg::work_t pending_work,
	output logic take,
	output logic mix_done,
	output scrypt_pkg::result_t mix_result
);
	import scrypt_pkg::*;

	// Steps within one BlockMix iteration
	localparam logic [1:0] STEP_FETCH = 2'd0;	// Mix phase only, address goes to the RAM
	localparam logic [1:0] STEP_LAUNCH = 2'd1;	// First Salsa pass starts
	localparam logic [1:0] STEP_HALF0 = 2'd2;	// Waiting for new X0
	localparam logic [1:0] STEP_HALF1 = 2'd3;	// Waiting for new X1

	romix_state_t state;
	logic [1:0] step;
	logic [SCRATCH_ADDR_BITS-1:0] idx;	// Iteration count, doubles as write address
	half_block_t x0;
	half_block_t x1;
	nonce_t job_nonce;

	logic salsa_start;
	logic salsa_done;
	half_block_t salsa_in;
	half_block_t salsa_out;
	logic [SCRATCH_ADDR_BITS-1:0] ram_addr;
	logic ram_wr_en;
	block_t ram_rd;
	half_block_t mix0;	// X0 after the scratchpad XOR
	half_block_t mix1;

	assign take = (state == ROMIX_IDLE) && pending_valid;

	// Scratchpad XOR applies only in the mix phase
	assign mix0 = (state == ROMIX_MIX) ? (x0 ^ ram_rd[511:0]) : x0;
	assign mix1 = (state == ROMIX_MIX) ? (x1 ^ ram_rd[1023:512]) : x1;

	// Second pass is X1 xor the fresh X0, straight off the core output
	assign salsa_in = (step == STEP_HALF0) ? (x1 ^ salsa_out) : (mix0 ^ mix1);
	assign salsa_start = (state != ROMIX_IDLE) &&
		((step == STEP_LAUNCH) || ((step == STEP_HALF0) && salsa_done));

	assign ram_wr_en = (state == ROMIX_WRITE) && (step == STEP_LAUNCH);	// Store X before mixing
	assign ram_addr = (state == ROMIX_MIX) ? x1[SCRATCH_ADDR_BITS-1:0] : idx;	// Word 16

	salsa_core u_salsa (
		.hash_clk(hash_clk),
		.reset(reset),
		.salsa_start(salsa_start),
		.salsa_in(salsa_in),
		.salsa_done(salsa_done),
		.salsa_out(salsa_out)
	);

	scratchpad_ram #(
		.SCRATCH_ADDR_BITS(SCRATCH_ADDR_BITS)
	) u_scratch (
		.hash_clk(hash_clk),
		.addr(ram_addr),
		.wr_data({x1, x0}),
		.wr_en(ram_wr_en),
		.rd_data(ram_rd)
	);

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			state <= ROMIX_IDLE;
			step <= STEP_LAUNCH;
			idx <= '0;
			mix_done <= 1'b0;
		end else begin
			mix_done <= 1'b0;
			case (state)
				ROMIX_IDLE: begin
					if (pending_valid) begin
						state <= ROMIX_WRITE;
						step <= STEP_LAUNCH;
						idx <= '0;
					end
				end
				ROMIX_WRITE, ROMIX_MIX: begin
					case (step)
						STEP_FETCH: step <= STEP_LAUNCH;	// RAM latches the address
						STEP_LAUNCH: step <= STEP_HALF0;
						STEP_HALF0: if (salsa_done) step <= STEP_HALF1;
						STEP_HALF1: begin
							if (salsa_done) begin
								idx <= idx + 1'b1;	// Wraps to zero on the last pass
								step <= STEP_FETCH;	// Mix phase needs a read first
								if (state == ROMIX_WRITE && idx != '1)
									step <= STEP_LAUNCH;
								if (idx == '1) begin
									if (state == ROMIX_WRITE) begin
										state <= ROMIX_MIX;
									end else begin
										state <= ROMIX_IDLE;
										mix_done <= 1'b1;
									end
								end
							end
						end
					endcase
				end
				default: state <= ROMIX_IDLE;
			endcase
		end
	end

	// X halves and the job nonce
	always_ff @(posedge hash_clk) begin
		if (take) begin
			x0 <= pending_work.block[511:0];
			x1 <= pending_work.block[1023:512];
			job_nonce <= pending_work.nonce;
		end else if (state != ROMIX_IDLE) begin
			if (step == STEP_LAUNCH) begin
				x0 <= mix0;
				x1 <= mix1;
			end
			if (step == STEP_HALF0 && salsa_done)
				x0 <= salsa_out;
			if (step == STEP_HALF1 && salsa_done)
				x1 <= salsa_out;
		end
	end

	// Final X is the new X1 over the current X0
	always_ff @(posedge hash_clk) begin
		if (state == ROMIX_MIX && step == STEP_HALF1 && salsa_done && idx == '1) begin
			mix_result.block <= {salsa_out, x0};
			mix_result.nonce <= job_nonce;
		end
	end

endmodule

`default_nettype wire

//--- logic/salsa_core.sv
/*
 * Iterative Salsa20/8 core
 * One column round and one row round per cycle, four cycles per pass,
 * then the feed-forward add of the saved input
 */
`timescale 1ns/1ps
`default_nettype none

module salsa_core (
	input logic hash_clk,
	input logic reset,
	input logic salsa_start,
	input scrypt_pkg::half_block_t salsa_in,
	output logic salsa_done,
	output scrypt_pkg::half_block_t salsa_out
);
	import scrypt_pkg::*;

	function automatic word_t rotl(word_t v, int unsigned n);
		return (v << n) | (v >> (32 - n));
	endfunction

	// Quarter round, returns {a, b, c, d} updated
	function automatic logic [127:0] quarter(word_t a, word_t b, word_t c, word_t d);
		word_t qa;
		word_t qb;
		word_t qc;
		word_t qd;
		qb = b ^ rotl(a + d, 7);
		qc = c ^ rotl(qb + a, 9);
		qd = d ^ rotl(qc + qb, 13);
		qa = a ^ rotl(qd + qc, 18);
		return {qa, qb, qc, qd};
	endfunction

	function automatic half_block_t double_round(half_block_t s);
		word_t w [16];
		half_block_t r;
		for (int i = 0; i < 16; i++)
			w[i] = s[32*i +: 32];	// Word 0 sits in the low bits
		// Column round
		{w[0], w[4], w[8], w[12]} = quarter(w[0], w[4], w[8], w[12]);
		{w[5], w[9], w[13], w[1]} = quarter(w[5], w[9], w[13], w[1]);
		{w[10], w[14], w[2], w[6]} = quarter(w[10], w[14], w[2], w[6]);
		{w[15], w[3], w[7], w[11]} = quarter(w[15], w[3], w[7], w[11]);
		// Row round
		{w[0], w[1], w[2], w[3]} = quarter(w[0], w[1], w[2], w[3]);
		{w[5], w[6], w[7], w[4]} = quarter(w[5], w[6], w[7], w[4]);
		{w[10], w[11], w[8], w[9]} = quarter(w[10], w[11], w[8], w[9]);
		{w[15], w[12], w[13], w[14]} = quarter(w[15], w[12], w[13], w[14]);
		for (int i = 0; i < 16; i++)
			r[32*i +: 32] = w[i];
		return r;
	endfunction

	function automatic half_block_t add_words(half_block_t a, half_block_t b);
		half_block_t r;
		for (int i = 0; i < 16; i++)
			r[32*i +: 32] = a[32*i +: 32] + b[32*i +: 32];	// Mod 2^32 per word
		return r;
	endfunction

	logic busy;
	logic [1:0] rnd;	// Double rounds already done
	half_block_t state;
	half_block_t saved_in;	// Kept for the feed-forward
	half_block_t dr_out;

	// First double round runs straight off the input in the start cycle
	assign dr_out = double_round(busy ? state : salsa_in);

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			busy <= 1'b0;
			rnd <= 2'd0;
			salsa_done <= 1'b0;
		end else begin
			salsa_done <= 1'b0;
			if (!busy && salsa_start) begin
				busy <= 1'b1;
				rnd <= 2'd1;
			end else if (busy) begin
				rnd <= rnd + 2'd1;
				if (rnd == 2'd3) begin	// Fourth double round this cycle
					busy <= 1'b0;
					salsa_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge hash_clk) begin
		if (!busy && salsa_start) begin
			state <= dr_out;
			saved_in <= salsa_in;
		end else if (busy) begin
			state <= dr_out;
			if (rnd == 2'd3)
				salsa_out <= add_words(dr_out, saved_in);
		end
	end

endmodule

`default_nettype wire

//--- logic/scratchpad_ram.sv
/*
 * ROMix scratchpad of full X blocks
 * Inputs registered, read unregistered, old data during a write
 */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_ram #(
	parameter int SCRATCH_ADDR_BITS = 10
) (
	input logic hash_clk,
	input logic [SCRATCH_ADDR_BITS-1:0] addr,
	input scrypt_pkg::block_t wr_data,
	input logic wr_en,
	output scrypt_pkg::block_t rd_data
);
	import scrypt_pkg::*;

	block_t mem [2**SCRATCH_ADDR_BITS];
	logic [SCRATCH_ADDR_BITS-1:0] addr_q;
	block_t wr_data_q;
	logic wr_en_q;

	always_ff @(posedge hash_clk) begin
		addr_q <= addr;
		wr_data_q <= wr_data;
		wr_en_q <= wr_en;
		if (wr_en_q)
			mem[addr_q] <= wr_data_q;	// Lands at the edge after the inputs were latched
	end

	assign rd_data = mem[addr_q];

endmodule

`default_nettype wire

//--- logic/scrypt_core.sv
/*
 * Scrypt mixing core top level
 * Nonce tracker feeds the ROMix engine, whose results go to the target check
 */
`timescale 1ns/1ps
`default_nettype none

module scrypt_core #(
	parameter int SCRATCH_ADDR_BITS = 10,	// Scratchpad depth is 2^SCRATCH_ADDR_BITS
	parameter int unsigned CORE_ID = 0
) (
	input logic hash_clk,
	input logic reset,
	input logic block_valid,
	input scrypt_pkg::block_t block_in,
	input scrypt_pkg::word_t nonce_seed,
	input logic load_nonce,
	input scrypt_pkg::word_t target,
	output scrypt_pkg::nonce_t nonce_out,
	output logic result_valid,
	output scrypt_pkg::result_t result,
	output logic golden_match,
	output scrypt_pkg::nonce_t golden_nonce
);
	import scrypt_pkg::*;

	logic pending_valid;
	work_t pending_work;
	logic take;
	logic mix_done;
	result_t mix_result;

	nonce_tracker #(
		.CORE_ID(CORE_ID)
	) u_tracker (
		.hash_clk(hash_clk),
		.reset(reset),
		.block_valid(block_valid),
		.block_in(block_in),
		.nonce_seed(nonce_seed),
		.load_nonce(load_nonce),
		.take(take),
		.pending_valid(pending_valid),
		.pending_work(pending_work),
		.nonce_out(nonce_out)
	);

	romix_engine #(
		.SCRATCH_ADDR_BITS(SCRATCH_ADDR_BITS)
	) u_romix (
		.hash_clk(hash_clk),
		.reset(reset),
		.pending_valid(pending_valid),
		.pending_work(pending_work),
		.take(take),
		.mix_done(mix_done),
		.mix_result(mix_result)
	);

	result_check u_check (
		.hash_clk(hash_clk),
		.reset(reset),
		.mix_done(mix_done),
		.mix_result(mix_result),
		.target(target),
		.result_valid(result_valid),
		.result(result),
		.golden_match(golden_match),
		.golden_nonce(golden_nonce)
	);

endmodule

`default_nettype wire

//--- logic/scrypt_pkg.sv
/*
 * Scrypt mixing core shared types
 * Salsa words, half blocks and full X blocks, the job and result records
 * and the mixer state encoding
 */
`default_nettype none

package scrypt_pkg;

	localparam int CORE_ID_BITS = 4;	// Core-id prefix at the top of the nonce

	typedef logic [31:0] word_t;	// One little-endian Salsa word
	typedef logic [511:0] half_block_t;	// Sixteen words, one Salsa pass
	typedef logic [1023:0] block_t;	// Full X state, X0 low and X1 high
	typedef logic [31:0] nonce_t;

	// Job waiting in the hand-off slot
	typedef struct packed {
		block_t block;
		nonce_t nonce;
	} work_t;

	// Mixed block together with the nonce it was tagged with
	typedef struct packed {
		block_t block;
		nonce_t nonce;
	} result_t;

	// Top level mixer sequencing
	typedef enum logic [1:0] {
		ROMIX_IDLE = 2'd0,
		ROMIX_WRITE = 2'd1,	// Filling the scratchpad
		ROMIX_MIX = 2'd2	// Data-dependent reads
	} romix_state_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
# Build and run the scrypt core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=scrypt_core_sim

verilator --binary --timing --assert -f sources.f --top-module scrypt_core_tb \
	--Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- sources.f
+incdir+verification
logic/scrypt_pkg.sv
logic/nonce_tracker.sv
logic/salsa_core.sv
logic/scratchpad_ram.sv
logic/romix_engine.sv
logic/result_check.sv
logic/scrypt_core.sv
verification/scrypt_core_tb.sv

//--- verification/salsa_model.svh
/*
 * Reference model of the scrypt mixing core
 * Salsa20/8, BlockMix, ROMix over a scratchpad and the golden target rule
 */
`ifndef SALSA_MODEL_SVH
`define SALSA_MODEL_SVH

function automatic word_t rotate_left(word_t v, int n);
	return (v << n) | (v >> (32 - n));
endfunction

// Quarter round on words a, b, c, d of a half block
function automatic half_block_t quarter_round(half_block_t s, int a, int b, int c, int d);
	word_t wa;
	word_t wb;
	word_t wc;
	word_t wd;
	wa = s[32*a +: 32];
	wb = s[32*b +: 32];
	wc = s[32*c +: 32];
	wd = s[32*d +: 32];
	wb = wb ^ rotate_left(wa + wd, 7);
	wc = wc ^ rotate_left(wb + wa, 9);
	wd = wd ^ rotate_left(wc + wb, 13);
	wa = wa ^ rotate_left(wd + wc, 18);
	s[32*a +: 32] = wa;
	s[32*b +: 32] = wb;
	s[32*c +: 32] = wc;
	s[32*d +: 32] = wd;
	return s;
endfunction

function automatic half_block_t salsa20_8(half_block_t src);
	half_block_t s;
	half_block_t sum;
	s = src;
	for (int r = 0; r < 4; r++) begin	// Eight rounds as four double rounds
		s = quarter_round(s, 0, 4, 8, 12);	// Columns
		s = quarter_round(s, 5, 9, 13, 1);
		s = quarter_round(s, 10, 14, 2, 6);
		s = quarter_round(s, 15, 3, 7, 11);
		s = quarter_round(s, 0, 1, 2, 3);	// Rows
		s = quarter_round(s, 5, 6, 7, 4);
		s = quarter_round(s, 10, 11, 8, 9);
		s = quarter_round(s, 15, 12, 13, 14);
	end
	for (int i = 0; i < 16; i++)
		sum[32*i +: 32] = s[32*i +: 32] + src[32*i +: 32];	// Feed-forward
	return sum;
endfunction

function automatic block_t blockmix(block_t x);
	half_block_t y0;
	half_block_t y1;
	y0 = salsa20_8(x[511:0] ^ x[1023:512]);
	y1 = salsa20_8(x[1023:512] ^ y0);
	return {y1, y0};
endfunction

function automatic block_t romix(block_t x, int depth);
	block_t pad [];
	int j;
	pad = new[depth];
	for (int i = 0; i < depth; i++) begin
		pad[i] = x;
		x = blockmix(x);
	end
	for (int i = 0; i < depth; i++) begin
		j = int'(x[512 +: 32] & word_t'(depth - 1));	// Low bits of word 16
		x = blockmix(x ^ pad[j]);
	end
	return x;
endfunction

// Top word byte-reversed, compared unsigned
function automatic bit below_target(block_t b, word_t limit);
	word_t w;
	w = b[1023:992];
	return {w[7:0], w[15:8], w[23:16], w[31:24]} < limit;
endfunction

`endif

//--- verification/scrypt_core_tb.sv
/*
 * Testbench for the scrypt mixing core
 * Random blocks against the ROMix model, nonce rules, golden strobe, slot drop
 */
`timescale 1ns/1ps
`default_nettype none

module scrypt_core_tb;
	import scrypt_pkg::*;

	localparam int ADDR_BITS = 3;
	localparam int DEPTH = 2 ** ADDR_BITS;
	localparam int unsigned CORE_ID = 5;
	localparam int COUNT_BITS = 32 - CORE_ID_BITS;
	localparam logic [CORE_ID_BITS-1:0] PREFIX = CORE_ID_BITS'(CORE_ID);
	localparam int CLK_PERIOD = 40;
	localparam int NUM_JOBS = 4;
	localparam int JOB_CYCLES = 2 * DEPTH * 16 + 32;	// Loose bound on one ROMix job
	localparam int WATCHDOG_CYCLES = (NUM_JOBS + 2) * JOB_CYCLES;	// Plus idle waits

	`include "salsa_model.svh"

	logic hash_clk;
	logic reset;
	logic block_valid;
	block_t block_in;
	word_t nonce_seed;
	logic load_nonce;
	word_t target;
	nonce_t nonce_out;
	logic result_valid;
	result_t result;
	logic golden_match;
	nonce_t golden_nonce;

	integer seed;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic [COUNT_BITS-1:0] exp_count;	// Model of the nonce counter
	word_t seed_word;
	result_t exp_queue [$];	// One entry per accepted block
	result_t popped;
	nonce_t last_golden = '0;

	scrypt_core #(
		.SCRATCH_ADDR_BITS(ADDR_BITS),
		.CORE_ID(CORE_ID)
	) uut (
		.hash_clk(hash_clk),
		.reset(reset),
		.block_valid(block_valid),
		.block_in(block_in),
		.nonce_seed(nonce_seed),
		.load_nonce(load_nonce),
		.target(target),
		.nonce_out(nonce_out),
		.result_valid(result_valid),
		.result(result),
		.golden_match(golden_match),
		.golden_nonce(golden_nonce)
	);

	initial begin
		hash_clk = 1'b0;
		forever #(CLK_PERIOD / 2) hash_clk = ~hash_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles with %0d results outstanding",
			WATCHDOG_CYCLES, exp_queue.size());
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic compare_value(input string name, input logic [1023:0] got,
		input logic [1023:0] expected);
		checks++;
		assert (got === expected) else begin
			value_errors++;
			$display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expected, got);
		end
	endtask

	function automatic block_t random_block();
		block_t b;
		for (int i = 0; i < 32; i++)
			b[32*i +: 32] = $random(seed);
		return b;
	endfunction

	function automatic nonce_t expected_nonce();
		return {PREFIX, exp_count};
	endfunction

	// Offers one block for a cycle, queues its result when the slot should take it
	task automatic send_block(input bit accepted);
		block_t blk;
		result_t r;
		blk = random_block();
		@(negedge hash_clk);
		block_valid = 1'b1;
		block_in = blk;
		if (accepted) begin
			r.block = romix(blk, DEPTH);
			r.nonce = expected_nonce();
			exp_queue.push_back(r);
			exp_count++;
		end
		@(negedge hash_clk);
		block_valid = 1'b0;
		compare_value("nonce_out", 1024'(nonce_out), 1024'(expected_nonce()));
	endtask

	task automatic wait_results();
		while (exp_queue.size() != 0)
			@(negedge hash_clk);
	endtask

	// Result, golden strobe and golden nonce checks
	always @(posedge hash_clk) begin
		if (!reset) begin
			assert (!golden_match || result_valid) else begin
				other_errors++;
				$display("golden_match pulsed without a result at %0t ns", $time);
			end
			if (result_valid) begin
				if (exp_queue.size() == 0) begin
					other_errors++;
					$display("Stray result at %0t ns with no accepted block outstanding", $time);
				end else begin
					popped = exp_queue.pop_front();
					compare_value("result.block", result.block, popped.block);
					compare_value("result.nonce", 1024'(result.nonce), 1024'(popped.nonce));
					compare_value("golden_match", 1024'(golden_match),
						1024'(below_target(popped.block, target)));
					if (below_target(popped.block, target))
						last_golden = popped.nonce;	// Held until the next hit
				end
			end
			compare_value("golden_nonce", 1024'(golden_nonce), 1024'(last_golden));
		end
	end

	initial begin
		seed = 32'h4789ac51;
		exp_count = '0;
		reset = 1'b1;
		block_valid = 1'b0;
		block_in = '0;
		nonce_seed = '0;
		load_nonce = 1'b0;
		target = '0;	// Never matches
		repeat (3) @(posedge hash_clk);
		@(negedge hash_clk);
		reset = 1'b0;

		// Outputs straight after reset
		compare_value("result_valid", 1024'(result_valid), 1024'(1'b0));
		compare_value("golden_match", 1024'(golden_match), 1024'(1'b0));
		compare_value("golden_nonce", 1024'(golden_nonce), 1024'(32'd0));
		compare_value("nonce_out", 1024'(nonce_out), 1024'(expected_nonce()));

		// Seed change reloads the counter
		seed_word = $random(seed);
		nonce_seed = seed_word;
		@(negedge hash_clk);
		exp_count = seed_word[COUNT_BITS-1:0];
		compare_value("nonce_out", 1024'(nonce_out), 1024'(expected_nonce()));

		send_block(1'b1);	// Goes straight to the mixer
		send_block(1'b1);	// Waits in the slot
		send_block(1'b0);	// Slot full, lost
		wait_results();
		repeat (JOB_CYCLES) @(negedge hash_clk);	// A lost block must not come out

		// Load strobe with the same seed, all-ones target
		target = '1;
		load_nonce = 1'b1;
		@(negedge hash_clk);
		load_nonce = 1'b0;
		exp_count = seed_word[COUNT_BITS-1:0];
		compare_value("nonce_out", 1024'(nonce_out), 1024'(expected_nonce()));

		send_block(1'b1);
		send_block(1'b1);
		wait_results();
		repeat (4) @(negedge hash_clk);

		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
